// File: axil_dot_regs.sv
`timescale 1ns/1ps

module axil_dot_regs import fixed_dot_pkg::*; #(
  parameter int DATA_WIDTH = DEF_DATA_WIDTH,
  parameter int OUT_WIDTH  = DEF_OUT_WIDTH,
  parameter int VEC_LEN    = DEF_VEC_LEN
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [AXIL_ADDR_WIDTH-1:0]    awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [AXIL_DATA_WIDTH-1:0]    wdata,
  input  logic [AXIL_STRB_WIDTH-1:0]    wstrb,
  input  logic                          wvalid,
  output logic                          wready,
  output axi_resp_t                     bresp,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic [AXIL_ADDR_WIDTH-1:0]    araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [AXIL_DATA_WIDTH-1:0]    rdata,
  output axi_resp_t                     rresp,
  output logic                          rvalid,
  input  logic                          rready,
  input  logic                          busy,
  input  logic                          done,
  input  logic [OUT_WIDTH-1:0]          result,
  output logic [VEC_LEN*DATA_WIDTH-1:0] x_vec,
  output logic [VEC_LEN*DATA_WIDTH-1:0] w_vec,
  output logic [DATA_WIDTH-1:0]         bias,
  output logic                          start
);

  reg_addr_t                  wr_word;
  reg_addr_t                  rd_word;
  logic                       wr_fire;
  logic                       wr_err;
  logic                       rd_fire;
  logic                       rvalid_nxt;
  int                         wr_xs;
  int                         wr_ws;
  logic [AXIL_DATA_WIDTH-1:0] wr_merged;

  // slot of a vector register, -1 when outside the active length
  function automatic int vec_slot(reg_addr_t word, reg_addr_t base);
    int offs;
    offs = int'(word) - int'(base);
    return (offs >= 0 && offs < VEC_LEN) ? offs : -1;
  endfunction

  function automatic logic [AXIL_DATA_WIDTH-1:0] sext_data(logic [DATA_WIDTH-1:0] v);
    return AXIL_DATA_WIDTH'($signed(v));
  endfunction

  function automatic logic is_mapped(reg_addr_t word);
    return (vec_slot(word, REG_X0) >= 0) || (vec_slot(word, REG_W0) >= 0) ||
           (word inside {REG_CTRL, REG_STATUS, REG_RESULT, REG_BIAS});
  endfunction

  // current register contents as the host sees them
  // ctrl and unmapped words read as zero
  function automatic logic [AXIL_DATA_WIDTH-1:0] reg_value(reg_addr_t word);
    int xs;
    int ws;
    xs = vec_slot(word, REG_X0);
    ws = vec_slot(word, REG_W0);
    if (xs >= 0) return sext_data(x_vec[xs*DATA_WIDTH +: DATA_WIDTH]);
    if (ws >= 0) return sext_data(w_vec[ws*DATA_WIDTH +: DATA_WIDTH]);
    case (word)
      REG_STATUS: return AXIL_DATA_WIDTH'({done, busy});
      REG_RESULT: return AXIL_DATA_WIDTH'($signed(result));
      REG_BIAS:   return sext_data(bias);
      default:    return '0;
    endcase
  endfunction

  // address and data are taken together, only with no response pending
  assign wr_word = reg_addr_t'(awaddr[AXIL_ADDR_WIDTH-1:2]);
  assign wr_fire = awvalid && wvalid && !bvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign wr_xs   = vec_slot(wr_word, REG_X0);
  assign wr_ws   = vec_slot(wr_word, REG_W0);
  // a start still in flight counts as busy
  assign wr_err  = busy || start || !is_mapped(wr_word) ||
                   (wr_word inside {REG_STATUS, REG_RESULT});

  // lanes without a strobe keep the old contents
  always_comb begin
    wr_merged = reg_value(wr_word);
    for (int b = 0; b < AXIL_STRB_WIDTH; b++) begin
      if (wstrb[b]) wr_merged[b*8 +: 8] = wdata[b*8 +: 8];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bvalid <= 1'b0;
      bresp  <= RESP_OKAY;
      start  <= 1'b0;
      bias   <= '0;
      x_vec  <= '0;
      w_vec  <= '0;
    end else begin
      // single-cycle pulse
      start <= 1'b0;
      if (wr_fire) begin
        bvalid <= 1'b1;
        bresp  <= wr_err ? RESP_SLVERR : RESP_OKAY;
        // rejected writes leave every register untouched
        if (!wr_err) begin
          if (wr_xs >= 0) begin
            x_vec[wr_xs*DATA_WIDTH +: DATA_WIDTH] <= wr_merged[DATA_WIDTH-1:0];
          end else if (wr_ws >= 0) begin
            w_vec[wr_ws*DATA_WIDTH +: DATA_WIDTH] <= wr_merged[DATA_WIDTH-1:0];
          end else if (wr_word == REG_BIAS) begin
            bias <= wr_merged[DATA_WIDTH-1:0];
          end else if (wr_word == REG_CTRL) begin
            start <= wr_merged[0];
          end
        end
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // read side, one outstanding response
  assign rd_word    = reg_addr_t'(araddr[AXIL_ADDR_WIDTH-1:2]);
  assign rd_fire    = arvalid && arready;
  assign rvalid_nxt = rd_fire || (rvalid && !rready);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rdata   <= '0;
      rresp   <= RESP_OKAY;
    end else begin
      rvalid  <= rvalid_nxt;
      // address channel reopens once the response is gone
      arready <= !rvalid_nxt;
      if (rd_fire) begin
        rdata <= reg_value(rd_word);
        rresp <= is_mapped(rd_word) ? RESP_OKAY : RESP_SLVERR;
      end
    end
  end

  a_bresp_hold: assert property (@(posedge clk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("write response changed before bready");

  a_rdata_hold: assert property (@(posedge clk) disable iff (!arst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("read response changed before rready");

endmodule

// File: fixed_dot_pkg.sv
package fixed_dot_pkg;

  // register bus geometry, byte addressed
  localparam int AXIL_ADDR_WIDTH = 6;
  localparam int AXIL_DATA_WIDTH = 32;
  localparam int AXIL_STRB_WIDTH = AXIL_DATA_WIDTH / 8;

  // default operand format, Q4.4 for inputs, weights and bias
  localparam int DEF_DATA_WIDTH = 8;
  localparam int DEF_DATA_FRAC  = 4;
  // default result format
  localparam int DEF_OUT_WIDTH  = 8;
  localparam int DEF_OUT_FRAC   = 4;
  // default vector length, 1 to 4 fit the register map
  localparam int DEF_VEC_LEN    = 4;

  // engine sequencing
  typedef enum logic [1:0] {
    MAC_IDLE  = 2'd0,
    MAC_ACC   = 2'd1,
    MAC_ROUND = 2'd2,
    MAC_DONE  = 2'd3
  } mac_state_t;

  // word addresses, byte address divided by 4
  typedef enum logic [3:0] {
    REG_CTRL   = 4'h0,
    REG_STATUS = 4'h1,
    REG_RESULT = 4'h2,
    REG_BIAS   = 4'h3,
    REG_X0     = 4'h4,
    REG_X1     = 4'h5,
    REG_X2     = 4'h6,
    REG_X3     = 4'h7,
    REG_W0     = 4'h8,
    REG_W1     = 4'h9,
    REG_W2     = 4'hA,
    REG_W3     = 4'hB
  } reg_addr_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

  // full-precision products plus growth for the sum of vec_len terms
  // the aligned bias fits in the same headroom
  function automatic int acc_width(int data_width, int vec_len);
    return 2 * data_width + $clog2(vec_len);
  endfunction

  // product scale, both operands carry data_frac fraction bits
  function automatic int acc_frac(int data_frac);
    return 2 * data_frac;
  endfunction

endpackage

// File: fixed_dot_top.sv
`timescale 1ns/1ps

module fixed_dot_top import fixed_dot_pkg::*; #(
  parameter int DATA_WIDTH = DEF_DATA_WIDTH,
  parameter int DATA_FRAC  = DEF_DATA_FRAC,
  parameter int OUT_WIDTH  = DEF_OUT_WIDTH,
  parameter int OUT_FRAC   = DEF_OUT_FRAC,
  parameter int VEC_LEN    = DEF_VEC_LEN
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [AXIL_ADDR_WIDTH-1:0] awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [AXIL_DATA_WIDTH-1:0] wdata,
  input  logic [AXIL_STRB_WIDTH-1:0] wstrb,
  input  logic                       wvalid,
  output logic                       wready,
  output axi_resp_t                  bresp,
  output logic                       bvalid,
  input  logic                       bready,
  input  logic [AXIL_ADDR_WIDTH-1:0] araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [AXIL_DATA_WIDTH-1:0] rdata,
  output axi_resp_t                  rresp,
  output logic                       rvalid,
  input  logic                       rready
);

  // accumulator format seen by the rounder
  localparam int ACC_WIDTH = acc_width(DATA_WIDTH, VEC_LEN);
  localparam int ACC_FRAC  = acc_frac(DATA_FRAC);

  logic [VEC_LEN*DATA_WIDTH-1:0] x_vec;
  logic [VEC_LEN*DATA_WIDTH-1:0] w_vec;
  logic [DATA_WIDTH-1:0]         bias;
  logic                          start;
  logic                          busy;
  logic                          done;
  logic [OUT_WIDTH-1:0]          result;
  logic [ACC_WIDTH-1:0]          acc_sum;
  logic [OUT_WIDTH-1:0]          round_out;

  // host registers
  axil_dot_regs #(
    .DATA_WIDTH (DATA_WIDTH),
    .OUT_WIDTH  (OUT_WIDTH),
    .VEC_LEN    (VEC_LEN)
  ) axil_dot_regs_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .busy    (busy),
    .done    (done),
    .result  (result),
    .x_vec   (x_vec),
    .w_vec   (w_vec),
    .bias    (bias),
    .start   (start)
  );

  // sequential multiply-accumulate
  fixed_mac_engine #(
    .DATA_WIDTH (DATA_WIDTH),
    .DATA_FRAC  (DATA_FRAC),
    .OUT_WIDTH  (OUT_WIDTH),
    .OUT_FRAC   (OUT_FRAC),
    .VEC_LEN    (VEC_LEN)
  ) fixed_mac_engine_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .x_vec     (x_vec),
    .w_vec     (w_vec),
    .bias      (bias),
    .round_out (round_out),
    .acc_sum   (acc_sum),
    .busy      (busy),
    .done      (done),
    .result    (result)
  );

  // wide sum down to the result format
  fixed_round #(
    .IN_WIDTH       (ACC_WIDTH),
    .IN_FRAC_WIDTH  (ACC_FRAC),
    .OUT_WIDTH      (OUT_WIDTH),
    .OUT_FRAC_WIDTH (OUT_FRAC)
  ) fixed_round_inst (
    .data_in  (acc_sum),
    .data_out (round_out)
  );

endmodule

// File: fixed_mac_engine.sv
`timescale 1ns/1ps

module fixed_mac_engine import fixed_dot_pkg::*; #(
  parameter int DATA_WIDTH = DEF_DATA_WIDTH,
  parameter int DATA_FRAC  = DEF_DATA_FRAC,
  parameter int OUT_WIDTH  = DEF_OUT_WIDTH,
  parameter int OUT_FRAC   = DEF_OUT_FRAC,
  parameter int VEC_LEN    = DEF_VEC_LEN,
  localparam int ACC_WIDTH = acc_width(DATA_WIDTH, VEC_LEN)
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          start,
  input  logic [VEC_LEN*DATA_WIDTH-1:0] x_vec,
  input  logic [VEC_LEN*DATA_WIDTH-1:0] w_vec,
  input  logic [DATA_WIDTH-1:0]         bias,
  input  logic [OUT_WIDTH-1:0]          round_out,
  output logic [ACC_WIDTH-1:0]          acc_sum,
  output logic                          busy,
  output logic                          done,
  output logic [OUT_WIDTH-1:0]          result
);

  // element counter, at least one bit wide
  localparam int IDX_WIDTH = (VEC_LEN > 1) ? $clog2(VEC_LEN) : 1;
  localparam logic [IDX_WIDTH-1:0] LAST_IDX = IDX_WIDTH'(VEC_LEN - 1);

  mac_state_t                     state;
  logic [IDX_WIDTH-1:0]           idx;
  logic signed [ACC_WIDTH-1:0]    acc;
  logic signed [DATA_WIDTH-1:0]   x_sel;
  logic signed [DATA_WIDTH-1:0]   w_sel;
  logic signed [2*DATA_WIDTH-1:0] prod;
  logic signed [ACC_WIDTH-1:0]    bias_aligned;

  // formats need a sign bit above the fraction
  initial begin
    assert (DATA_FRAC < DATA_WIDTH && OUT_FRAC < OUT_WIDTH)
      else $error("fixed_mac_engine: fraction width exceeds format width");
  end

  // operands are read live, the register block freezes them while busy
  assign x_sel = x_vec[idx*DATA_WIDTH +: DATA_WIDTH];
  assign w_sel = w_vec[idx*DATA_WIDTH +: DATA_WIDTH];
  // exact signed product, no truncation
  assign prod  = x_sel * w_sel;

  // bias moved to product scale
  assign bias_aligned = ACC_WIDTH'($signed(bias)) <<< DATA_FRAC;

  // rounder sits outside, it sees the running sum
  assign acc_sum = acc;
  assign busy    = (state == MAC_ACC) || (state == MAC_ROUND);
  assign done    = (state == MAC_DONE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= MAC_IDLE;
      idx    <= '0;
      acc    <= '0;
      result <= '0;
    end else begin
      case (state)
        MAC_IDLE, MAC_DONE: begin
          // a new job seeds the sum with the bias
          if (start) begin
            acc   <= bias_aligned;
            idx   <= '0;
            state <= MAC_ACC;
          end
        end
        MAC_ACC: begin
          // one element per cycle
          acc <= acc + ACC_WIDTH'(prod);
          idx <= idx + 1'b1;
          if (idx == LAST_IDX) begin
            state <= MAC_ROUND;
          end
        end
        MAC_ROUND: begin
          // sum is final, capture the rounded value
          result <= round_out;
          state  <= MAC_DONE;
        end
        default: begin
          state <= MAC_IDLE;
        end
      endcase
    end
  end

  // the register block must hold start off while a job runs
  a_start_when_free: assert property (@(posedge clk) disable iff (!arst_n)
    start |-> (state == MAC_IDLE || state == MAC_DONE))
    else $error("start pulse reached a running engine");

  // live operands must not move under a running job
  a_operands_frozen: assert property (@(posedge clk) disable iff (!arst_n)
    busy |=> $stable(x_vec) && $stable(w_vec))
    else $error("operands changed while the engine was busy");

endmodule

// File: fixed_round.sv
`timescale 1ns/1ps

module fixed_round #(
  parameter int IN_WIDTH       = 8,
  parameter int IN_FRAC_WIDTH  = 3,
  parameter int OUT_WIDTH      = 3,
  parameter int OUT_FRAC_WIDTH = 1
) (
  input  logic [IN_WIDTH-1:0]  data_in,
  output logic [OUT_WIDTH-1:0] data_out
);

  // bits dropped below the output fraction point, negative means bits added
  localparam int SHIFT = IN_FRAC_WIDTH - OUT_FRAC_WIDTH;
  // room for the magnitude, a left shift and the rounding carry
  localparam int RND_WIDTH = IN_WIDTH + OUT_WIDTH + 1;
  // largest positive code and magnitude of the most negative code
  localparam logic [RND_WIDTH-1:0] MAX_POS = (RND_WIDTH'(1) << (OUT_WIDTH - 1)) - 1'b1;
  localparam logic [RND_WIDTH-1:0] MAX_NEG = RND_WIDTH'(1) << (OUT_WIDTH - 1);

  logic                 in_sign;
  logic [IN_WIDTH-1:0]  in_mag;
  logic [RND_WIDTH-1:0] rnd_mag;

  assign in_sign = data_in[IN_WIDTH-1];
  // magnitude kept at full width so the most negative input is not lost
  assign in_mag = in_sign ? (~data_in + 1'b1) : data_in;

  if (SHIFT > 0) begin : g_round
    // everything below the guard bit
    localparam logic [IN_WIDTH-1:0] STICKY_MASK = (IN_WIDTH'(1) << (SHIFT - 1)) - 1'b1;

    logic [IN_WIDTH-1:0] kept;
    logic                guard_bit;
    logic                sticky_bit;
    logic                carry;

    assign kept       = in_mag >> SHIFT;
    // first dropped bit
    assign guard_bit  = in_mag[SHIFT-1];
    assign sticky_bit = |(in_mag & STICKY_MASK);
    // above half rounds up, exact half rounds to the even neighbour
    assign carry      = guard_bit & (kept[0] | sticky_bit);
    assign rnd_mag    = RND_WIDTH'(kept) + RND_WIDTH'(carry);
  end else if (SHIFT == 0) begin : g_pass
    // same fraction, nothing to round
    assign rnd_mag = RND_WIDTH'(in_mag);
  end else begin : g_widen
    // output is finer than the input, pad with zero fraction bits
    assign rnd_mag = RND_WIDTH'(in_mag) << (-SHIFT);
  end

  // clamp to the signed output range and put the sign back
  always_comb begin
    if (!in_sign) begin
      if (rnd_mag >= MAX_POS) begin
        data_out = MAX_POS[OUT_WIDTH-1:0];
      end else begin
        data_out = rnd_mag[OUT_WIDTH-1:0];
      end
    end else if (rnd_mag >= MAX_NEG) begin
      // negative overflow pins to the most negative code
      data_out = MAX_NEG[OUT_WIDTH-1:0];
    end else if (rnd_mag == '0) begin
      // small negative values collapse to plain zero
      data_out = '0;
    end else begin
      data_out = ~rnd_mag[OUT_WIDTH-1:0] + 1'b1;
    end
  end

endmodule

// File: flist.f
fixed_dot_pkg.sv
fixed_round.sv
fixed_mac_engine.sv
axil_dot_regs.sv
fixed_dot_top.sv
tb_fixed_dot_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dot-product testbench with verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fixed_dot_top -f flist.f -o sim_dot

# a fatal check makes the simulator exit non-zero, the log decides
./obj_dir/sim_dot > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
  echo "RESULT: FAIL"
  exit 1
fi
if ! grep -q "Test completed successfully" "$LOG"; then
  echo "RESULT: FAIL, simulation ended without a verdict"
  exit 1
fi
echo "RESULT: PASS"

// File: tb_fixed_dot_top.sv
`timescale 1ns/1ps

module tb_fixed_dot_top import fixed_dot_pkg::*; ();

  localparam int TIMEOUT     = 50;
  localparam int POLL_LIMIT  = 40;
  localparam int NROWS       = 9;
  localparam int NRAND       = 24;
  // bias lsb in product units, and one result lsb in product units
  localparam int BIAS_SCALE  = 1 << DEF_DATA_FRAC;
  localparam int RND_STEP    = 1 << (2 * DEF_DATA_FRAC - DEF_OUT_FRAC);
  localparam int OUT_MAX     = (1 << (DEF_OUT_WIDTH - 1)) - 1;
  localparam int OUT_MIN_MAG = 1 << (DEF_OUT_WIDTH - 1);

  logic                       clk = 1'b0;
  logic                       arst_n;
  logic [AXIL_ADDR_WIDTH-1:0] awaddr;
  logic                       awvalid;
  logic                       awready;
  logic [AXIL_DATA_WIDTH-1:0] wdata;
  logic [AXIL_STRB_WIDTH-1:0] wstrb;
  logic                       wvalid;
  logic                       wready;
  axi_resp_t                  bresp;
  logic                       bvalid;
  logic                       bready;
  logic [AXIL_ADDR_WIDTH-1:0] araddr;
  logic                       arvalid;
  logic                       arready;
  logic [AXIL_DATA_WIDTH-1:0] rdata;
  axi_resp_t                  rresp;
  logic                       rvalid;
  logic                       rready;

  int seed;
  // longest random hold of bready / rready, 0 keeps them ready
  int max_stall;
  int cur_x [DEF_VEC_LEN];
  int cur_w [DEF_VEC_LEN];
  int cur_b;

  // Q4.4 codes, products are in 2^-8 units
  int tab_x [NROWS][DEF_VEC_LEN] = '{
    '{16, 16, 16, 16},
    '{5, 0, 0, 0},
    '{7, 0, 0, 0},
    '{41, 0, 0, 0},
    '{-7, 0, 0, 0},
    '{-1, 0, 0, 0},
    '{127, 127, 127, 127},
    '{-128, -128, -128, -128},
    '{3, -5, 7, 2}
  };
  int tab_w [NROWS][DEF_VEC_LEN] = '{
    '{16, 32, 0, 0},
    '{8, 0, 0, 0},
    '{8, 0, 0, 0},
    '{1, 0, 0, 0},
    '{8, 0, 0, 0},
    '{8, 0, 0, 0},
    '{127, 127, 127, 127},
    '{127, 127, 127, 127},
    '{9, 4, -2, 11}
  };
  int tab_b [NROWS] = '{16, 0, 0, 0, 0, 0, 127, -128, 1};
  // exact 4.0, tie to 2, tie to 4, above tie, -tie, -0, sat+, sat-, mixed
  logic [DEF_OUT_WIDTH-1:0] tab_exp [NROWS] = '{
    8'h40, 8'h02, 8'h04, 8'h03, 8'hFC, 8'h00, 8'h7F, 8'h80, 8'h02
  };

  fixed_dot_top fixed_dot_top_inst (.*);

  always #2 clk = ~clk;

  task automatic abort_test(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_test($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
    if (got !== exp) begin
      abort_test($sformatf("Fail at %0t: %s is %s, expected %s", $time, name,
                           got.name(), exp.name()));
    end
  endtask

  function automatic logic [31:0] sign_extend(input logic [7:0] v);
    return {{24{v[7]}}, v};
  endfunction

  function automatic logic [AXIL_ADDR_WIDTH-1:0] byte_addr(input reg_addr_t r, input int offs);
    return {r, 2'b00} + AXIL_ADDR_WIDTH'(4 * offs);
  endfunction

  // exact sum, then nearest-even on the magnitude and clamp
  function automatic logic [DEF_OUT_WIDTH-1:0] model_result();
    int sum;
    int mag;
    int q;
    int r;
    sum = cur_b * BIAS_SCALE;
    for (int i = 0; i < DEF_VEC_LEN; i++) begin
      sum = sum + cur_x[i] * cur_w[i];
    end
    mag = (sum < 0) ? -sum : sum;
    q = mag / RND_STEP;
    r = mag % RND_STEP;
    if (r > RND_STEP / 2 || (r == RND_STEP / 2 && q % 2 == 1)) begin
      q = q + 1;
    end
    if (sum >= 0) begin
      return DEF_OUT_WIDTH'((q > OUT_MAX) ? OUT_MAX : q);
    end
    return DEF_OUT_WIDTH'(-((q > OUT_MIN_MAG) ? OUT_MIN_MAG : q));
  endfunction

  task automatic axil_write(input logic [AXIL_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                            output axi_resp_t resp);
    int n;
    int cnt;
    n = (max_stall > 0) ? int'($unsigned($random(seed)) % (max_stall + 1)) : 0;
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= '1;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    // no stall means bready is already up when bvalid arrives
    bready  <= (n == 0);
    cnt = 0;
    @(negedge clk);
    while (!(awready && wready)) begin
      cnt++;
      if (cnt > TIMEOUT) abort_test("timeout, write address and data never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    cnt = 0;
    @(negedge clk);
    while (!bvalid) begin
      cnt++;
      if (cnt > TIMEOUT) abort_test("timeout, write response never arrived");
      @(negedge clk);
    end
    resp = bresp;
    // response must hold while bready is low
    repeat (n) begin
      @(negedge clk);
      if (!bvalid) abort_test("write response dropped before bready");
      check_resp("bresp", bresp, resp);
    end
    if (n != 0) begin
      @(posedge clk);
      bready <= 1'b1;
    end
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [AXIL_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
                           output axi_resp_t resp);
    int n;
    int cnt;
    n = (max_stall > 0) ? int'($unsigned($random(seed)) % (max_stall + 1)) : 0;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= (n == 0);
    cnt = 0;
    @(negedge clk);
    while (!arready) begin
      cnt++;
      if (cnt > TIMEOUT) abort_test("timeout, read address never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    arvalid <= 1'b0;
    cnt = 0;
    @(negedge clk);
    while (!rvalid) begin
      cnt++;
      if (cnt > TIMEOUT) abort_test("timeout, read data never arrived");
      @(negedge clk);
    end
    data = rdata;
    resp = rresp;
    repeat (n) begin
      @(negedge clk);
      if (!rvalid) abort_test("read response dropped before rready");
      check_data("rdata", rdata, data);
      check_resp("rresp", rresp, resp);
    end
    if (n != 0) begin
      @(posedge clk);
      rready <= 1'b1;
    end
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic load_operands();
    axi_resp_t resp;
    for (int i = 0; i < DEF_VEC_LEN; i++) begin
      axil_write(byte_addr(REG_X0, i), 32'(cur_x[i]), resp);
      check_resp("bresp x write", resp, RESP_OKAY);
      axil_write(byte_addr(REG_W0, i), 32'(cur_w[i]), resp);
      check_resp("bresp w write", resp, RESP_OKAY);
    end
    axil_write(byte_addr(REG_BIAS, 0), 32'(cur_b), resp);
    check_resp("bresp bias write", resp, RESP_OKAY);
  endtask

  task automatic start_job();
    axi_resp_t resp;
    axil_write(byte_addr(REG_CTRL, 0), 32'h1, resp);
    check_resp("bresp start", resp, RESP_OKAY);
  endtask

  // poll status until done, then done only
  task automatic wait_done();
    axi_resp_t   resp;
    logic [31:0] data;
    int          polls;
    polls = 0;
    data = '0;
    while (!data[1]) begin
      polls++;
      if (polls > POLL_LIMIT) abort_test("timeout, engine never reported done");
      axil_read(byte_addr(REG_STATUS, 0), data, resp);
      check_resp("rresp status", resp, RESP_OKAY);
    end
    check_data("status after done", data, 32'h2);
  endtask

  task automatic check_result(input logic [DEF_OUT_WIDTH-1:0] exp);
    axi_resp_t   resp;
    logic [31:0] data;
    axil_read(byte_addr(REG_RESULT, 0), data, resp);
    check_resp("rresp result", resp, RESP_OKAY);
    check_data("result", data, sign_extend(exp));
  endtask

  // table row into the operand set, the model must agree with the row
  task automatic pick_row(input int r);
    for (int i = 0; i < DEF_VEC_LEN; i++) begin
      cur_x[i] = tab_x[r][i];
      cur_w[i] = tab_w[r][i];
    end
    cur_b = tab_b[r];
    check_data("table expected value", sign_extend(tab_exp[r]), sign_extend(model_result()));
  endtask

  task automatic run_row(input int r);
    pick_row(r);
    load_operands();
    start_job();
    wait_done();
    check_result(tab_exp[r]);
  endtask

  initial begin
    axi_resp_t   resp;
    logic [31:0] data;
    logic [7:0]  v;
    arst_n  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    seed      = 32'h24df;
    max_stall = 0;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    // idle status and cleared result
    axil_read(byte_addr(REG_STATUS, 0), data, resp);
    check_resp("rresp status", resp, RESP_OKAY);
    check_data("status after reset", data, 32'h0);
    axil_read(byte_addr(REG_RESULT, 0), data, resp);
    check_resp("rresp result", resp, RESP_OKAY);
    check_data("result after reset", data, 32'h0);

    // bias, x0..x3 and w0..w3 sit at consecutive words
    // upper write bits carry junk that must not be stored
    for (int i = 0; i < 2 * DEF_VEC_LEN + 1; i++) begin
      v = 8'(8'h6B * (i + 1));
      axil_write(byte_addr(REG_BIAS, i), 32'hA5A5_A500 | 32'(v), resp);
      check_resp("bresp operand write", resp, RESP_OKAY);
    end
    for (int i = 0; i < 2 * DEF_VEC_LEN + 1; i++) begin
      v = 8'(8'h6B * (i + 1));
      axil_read(byte_addr(REG_BIAS, i), data, resp);
      check_resp("rresp operand read", resp, RESP_OKAY);
      check_data("operand readback", data, sign_extend(v));
    end

    // rounding and saturation rows
    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
    end

    // busy protection, writes land inside the busy window
    pick_row(NROWS - 1);
    load_operands();
    start_job();
    axil_write(byte_addr(REG_X0, 0), 32'h55, resp);
    check_resp("bresp x0 while busy", resp, RESP_SLVERR);
    axil_write(byte_addr(REG_CTRL, 0), 32'h1, resp);
    check_resp("bresp ctrl while busy", resp, RESP_SLVERR);
    wait_done();
    check_result(tab_exp[NROWS-1]);
    axil_read(byte_addr(REG_X0, 0), data, resp);
    check_resp("rresp x0 after rejected write", resp, RESP_OKAY);
    check_data("x0 after rejected write", data, sign_extend(8'(cur_x[0])));
    axil_write(byte_addr(REG_RESULT, 0), 32'h12, resp);
    check_resp("bresp result write", resp, RESP_SLVERR);
    axil_write(6'h30, 32'h34, resp);
    check_resp("bresp unmapped write", resp, RESP_SLVERR);
    axil_read(6'h30, data, resp);
    check_resp("rresp unmapped read", resp, RESP_SLVERR);
    check_data("unmapped read data", data, 32'h0);

    // same rows with bready and rready held back
    max_stall = 6;
    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
    end

    // random operands, every other row small so it stays in range
    max_stall = 2;
    for (int n = 0; n < NRAND; n++) begin
      for (int i = 0; i < DEF_VEC_LEN; i++) begin
        if (n % 2 == 0) begin
          cur_x[i] = int'($signed(8'($random(seed))));
          cur_w[i] = int'($signed(8'($random(seed))));
        end else begin
          cur_x[i] = $random(seed) % 20;
          cur_w[i] = $random(seed) % 20;
        end
      end
      cur_b = int'($signed(8'($random(seed))));
      load_operands();
      start_job();
      wait_done();
      check_result(model_result());
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule
